// File: vlog.f
axi_pkg.sv
sys_bus_pkg.sv
axi_wr_channel.sv
axi_rd_channel.sv
sys_bus_sequencer.sv
ps_bus_bridge.sv
tb_ps_bus_bridge.sv

// File: Bender.yml
package:
  name: ps_bus_bridge

sources:
  - axi_pkg.sv
  - sys_bus_pkg.sv
  - axi_wr_channel.sv
  - axi_rd_channel.sv
  - sys_bus_sequencer.sv
  - ps_bus_bridge.sv
  - target: simulation
    files:
      - tb_ps_bus_bridge.sv

// File: tb_ps_bus_bridge.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the PS GP0 to system bus bridge
// AXI master stimulus, strobe/ack slave model with error and hang
// addresses, reference model and B/R response checker
//////////////////////////////////////////////////////////////////////

module tb_ps_bus_bridge;

localparam int T_DRV   = 5;                         // drive delay after edge
localparam int NUM_TXN = 2*8 + 2*8 + 2*3 + 2*2 + 2 + 2*24;
localparam int MAX_CYC = (sys_bus_pkg::SYS_TIMEOUT_CYCLES + 20) * NUM_TXN;

logic axi_clk_i = 1'b0;
logic rst_i;
axi_pkg::axi_id_t       axi_awid_i, axi_arid_i, axi_bid_o, axi_rid_o;
axi_pkg::axi_addr_t     axi_awaddr_i, axi_araddr_i;
axi_pkg::axi_len_t      axi_awlen_i, axi_arlen_i;
axi_pkg::axi_data_t     axi_wdata_i, axi_rdata_o;
axi_pkg::axi_strb_t     axi_wstrb_i;
axi_pkg::axi_resp_t     axi_bresp_o, axi_rresp_o;
logic                   axi_awvalid_i, axi_awready_o, axi_wlast_i, axi_wvalid_i, axi_wready_o;
logic                   axi_bvalid_o, axi_bready_i, axi_arvalid_i, axi_arready_o;
logic                   axi_rlast_o, axi_rvalid_o, axi_rready_i;
sys_bus_pkg::sys_addr_t sys_addr_o;
sys_bus_pkg::sys_data_t sys_wdata_o, sys_rdata_i;
sys_bus_pkg::sys_sel_t  sys_sel_o;
logic                   sys_wen_o, sys_ren_o, sys_err_i, sys_ack_i;

logic [31:0] rng_state = 32'ha201;
logic [31:0] shadow [64];                           // reference copy of slave memory
logic [31:0] slave_mem [64];
logic [13:0] exp_b [$];                             // {id, resp}
logic [45:0] exp_r [$];                             // {id, resp, data}
logic [13:0] b_exp;
logic [45:0] r_exp;
logic [31:0] slave_addr;
logic [31:0] slave_rnd;
logic [31:0] stall_rnd;
logic        stall_en = 1'b0;                       // random bready/rready
int          txn_cnt = 0;
int          strobe_cnt = 0;
int          cycle_cnt = 0;
int          err_cnt = 0;

ps_bus_bridge u_dut (.*);

always #50 axi_clk_i = ~axi_clk_i;

//////////////////////////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);        // xorshift32
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic logic [31:0] fill_word(input int idx);
  return 32'hc0de_0000 ^ (idx * 32'h0104_1041);     // unique per word
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word, new_word,
                                            input logic [3:0] strb);
  logic [31:0] res;
  res = old_word;
  for (int b = 0; b < 4; b++)
    if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
  return res;
endfunction

// expected {resp, rdata} per slave address class
function automatic logic [33:0] ref_result(input logic [31:0] addr);
  if (addr[21])
    return {axi_pkg::RESP_SLVERR, 32'h0};
  else if (addr[20])
    return {axi_pkg::RESP_SLVERR, shadow[addr[7:2]]};
  else
    return {axi_pkg::RESP_OKAY, shadow[addr[7:2]]};
endfunction

function automatic logic [31:0] make_addr(input logic [5:0] idx, input logic err, hang);
  logic [31:0] r;
  r = next_rand();
  return {10'h0, hang, err, r[11:0], idx, 2'b00};   // upper bits ignored by slave
endfunction

task automatic flag_mismatch(input string name, input logic [31:0] got, exp);
  err_cnt++;
  $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
  $display("FAIL: see errors above");
  $fatal(1);
endtask

task automatic stop_with_error(input string what);
  err_cnt++;
  $display("** Error at time %0t: %s", $time, what);
  $display("FAIL: see errors above");
  $fatal(1);
endtask

task automatic send_aw(input logic [11:0] id, input logic [31:0] addr);
  axi_awid_i    = id;
  axi_awaddr_i  = addr;
  axi_awvalid_i = 1'b1;
  @(negedge axi_clk_i);
  while (!axi_awready_o) @(negedge axi_clk_i);      // busy until previous B taken
  @(posedge axi_clk_i);
  #T_DRV;
  axi_awvalid_i = 1'b0;
endtask

task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
  axi_wdata_i  = data;
  axi_wstrb_i  = strb;
  axi_wvalid_i = 1'b1;
  @(negedge axi_clk_i);
  while (!axi_wready_o) @(negedge axi_clk_i);
  @(posedge axi_clk_i);
  #T_DRV;
  axi_wvalid_i = 1'b0;
endtask

task automatic send_ar(input logic [11:0] id, input logic [31:0] addr);
  axi_arid_i    = id;
  axi_araddr_i  = addr;
  axi_arvalid_i = 1'b1;
  @(negedge axi_clk_i);
  while (!axi_arready_o) @(negedge axi_clk_i);
  @(posedge axi_clk_i);
  #T_DRV;
  axi_arvalid_i = 1'b0;
endtask

task automatic write_random(input logic [5:0] idx, input logic err, hang, full, w_first);
  logic [31:0] addr;
  logic [31:0] data;
  logic [31:0] r;
  logic [3:0]  strb;
  logic [33:0] ref_val;
  addr    = make_addr(idx, err, hang);
  data    = next_rand();
  r       = next_rand();
  strb    = full ? 4'hf : r[3:0];
  ref_val = ref_result(addr);
  exp_b.push_back({r[15:4], ref_val[33:32]});
  if (!err && !hang) shadow[idx] = merge_bytes(shadow[idx], data, strb);
  txn_cnt++;
  if (w_first) begin                                // data before address
    send_w(data, strb);
    send_aw(r[15:4], addr);
  end else begin
    send_aw(r[15:4], addr);
    send_w(data, strb);
  end
endtask

task automatic read_random(input logic [5:0] idx, input logic err, hang);
  logic [31:0] addr;
  logic [31:0] r;
  logic [33:0] ref_val;
  addr    = make_addr(idx, err, hang);
  r       = next_rand();
  ref_val = ref_result(addr);
  exp_r.push_back({r[11:0], ref_val});
  txn_cnt++;
  send_ar(r[11:0], addr);
endtask

task automatic wait_drained();
  while (exp_b.size() != 0 || exp_r.size() != 0) @(posedge axi_clk_i);
  @(posedge axi_clk_i);
  #T_DRV;
endtask

//////////////////////////////////////////////////////////////////////
// system bus slave, ready stalls, strobe count, cycle limit
//////////////////////////////////////////////////////////////////////

initial begin : slave_model
  sys_ack_i   = 1'b0;
  sys_err_i   = 1'b0;
  sys_rdata_i = '0;
  for (int i = 0; i < 64; i++) slave_mem[i] = fill_word(i);
  forever begin
    @(posedge axi_clk_i);
    #T_DRV;
    if (!rst_i && (sys_wen_o || sys_ren_o)) begin
      slave_addr = sys_addr_o;
      assert (sys_wen_o || sys_sel_o == 4'hf)
        else flag_mismatch("sys_sel_o", sys_sel_o, 32'hf);
      if (sys_wen_o && !slave_addr[20] && !slave_addr[21])
        slave_mem[slave_addr[7:2]] =
          merge_bytes(slave_mem[slave_addr[7:2]], sys_wdata_o, sys_sel_o);
      if (!slave_addr[21]) begin                    // bit 21 never answers
        slave_rnd = next_rand();
        repeat (slave_rnd[1:0]) begin               // 0..3 cycles of wait
          @(posedge axi_clk_i);
          #T_DRV;
        end
        sys_ack_i   = 1'b1;
        sys_err_i   = slave_addr[20];
        sys_rdata_i = slave_mem[slave_addr[7:2]];
        @(posedge axi_clk_i);
        #T_DRV;
        sys_ack_i   = 1'b0;
        sys_err_i   = 1'b0;
        sys_rdata_i = '0;
      end
    end
  end
end

always @(posedge axi_clk_i) begin
  #T_DRV;
  stall_rnd    = next_rand();
  axi_bready_i = !stall_en || stall_rnd[0] || stall_rnd[1];   // low about 1 in 4
  axi_rready_i = !stall_en || stall_rnd[2];                   // low about 1 in 2
end

always @(negedge axi_clk_i)
  if (sys_wen_o || sys_ren_o) strobe_cnt++;         // one per strobe cycle

always @(posedge axi_clk_i) begin
  cycle_cnt++;
  assert (cycle_cnt <= MAX_CYC)
    else stop_with_error("cycle limit reached, the bridge stopped responding");
end

//////////////////////////////////////////////////////////////////////
// B and R checker sampling beats before their handshake edge
//////////////////////////////////////////////////////////////////////

always @(negedge axi_clk_i) begin
  if (!rst_i && axi_bvalid_o && axi_bready_i) begin
    assert (exp_b.size() > 0) else stop_with_error("B beat with no write outstanding");
    b_exp = exp_b.pop_front();
    assert (axi_bid_o == b_exp[13:2])
      else flag_mismatch("axi_bid_o", axi_bid_o, b_exp[13:2]);
    assert (axi_bresp_o == b_exp[1:0])
      else flag_mismatch("axi_bresp_o", axi_bresp_o, b_exp[1:0]);
  end
  if (!rst_i && axi_rvalid_o && axi_rready_i) begin
    assert (exp_r.size() > 0) else stop_with_error("R beat with no read outstanding");
    r_exp = exp_r.pop_front();
    assert (axi_rid_o == r_exp[45:34])
      else flag_mismatch("axi_rid_o", axi_rid_o, r_exp[45:34]);
    assert (axi_rresp_o == r_exp[33:32])
      else flag_mismatch("axi_rresp_o", axi_rresp_o, r_exp[33:32]);
    assert (axi_rdata_o == r_exp[31:0])
      else flag_mismatch("axi_rdata_o", axi_rdata_o, r_exp[31:0]);
    assert (axi_rlast_o) else stop_with_error("axi_rlast_o low on a single-beat read");
  end
end

//////////////////////////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////////////////////////

initial begin
  for (int i = 0; i < 64; i++) shadow[i] = fill_word(i);
  rst_i         = 1'b1;
  axi_awid_i    = '0;
  axi_awaddr_i  = '0;
  axi_awlen_i   = '0;                               // single beats only
  axi_awvalid_i = 1'b0;
  axi_wdata_i   = '0;
  axi_wstrb_i   = '0;
  axi_wlast_i   = 1'b1;
  axi_wvalid_i  = 1'b0;
  axi_bready_i  = 1'b1;
  axi_arid_i    = '0;
  axi_araddr_i  = '0;
  axi_arlen_i   = '0;
  axi_arvalid_i = 1'b0;
  axi_rready_i  = 1'b1;
  repeat (4) @(posedge axi_clk_i);
  #T_DRV;
  rst_i = 1'b0;
  assert (axi_awready_o && axi_wready_o && axi_arready_o && !axi_bvalid_o &&
          !axi_rvalid_o && !sys_wen_o && !sys_ren_o)
    else stop_with_error("bridge outputs not at their reset values");

  // full words then read back
  for (int i = 0; i < 8; i++) write_random(6'(i), 1'b0, 1'b0, 1'b1, i[0]);
  wait_drained();
  for (int i = 0; i < 8; i++) read_random(6'(i), 1'b0, 1'b0);
  wait_drained();
  // partial strobes merge into the old word
  for (int i = 0; i < 8; i++) write_random(6'(i), 1'b0, 1'b0, 1'b0, i[0]);
  wait_drained();
  for (int i = 0; i < 8; i++) read_random(6'(i), 1'b0, 1'b0);
  wait_drained();
  // slave error flag leaves memory as it was
  for (int i = 0; i < 3; i++) write_random(6'(i + 8), 1'b1, 1'b0, 1'b1, 1'b0);
  wait_drained();
  for (int i = 0; i < 3; i++) read_random(6'(i + 8), 1'b1, 1'b0);
  wait_drained();
  // no ack at all then an ordinary pair
  for (int i = 0; i < 2; i++) begin
    write_random(6'(i + 12), 1'b0, 1'b1, 1'b1, i[0]);
    read_random(6'(i), 1'b0, 1'b1);
    wait_drained();
  end
  write_random(6'd14, 1'b0, 1'b0, 1'b1, 1'b0);
  wait_drained();
  read_random(6'd14, 1'b0, 1'b0);
  wait_drained();
  // concurrent traffic with writes in the low half and reads in the high half
  stall_en = 1'b1;
  fork
    for (int i = 0; i < 24; i++)
      write_random(6'(next_rand() & 32'd31), 1'b0, 1'b0, 1'b0, i[0]);
    for (int i = 0; i < 24; i++)
      read_random(6'(32 + (next_rand() & 32'd31)), 1'b0, 1'b0);
  join
  wait_drained();
  stall_en = 1'b0;

  assert (strobe_cnt == txn_cnt) else flag_mismatch("bus strobe count", strobe_cnt, txn_cnt);
  if (err_cnt == 0) begin
    $display("PASS: all tests");
    $finish;
  end else begin
    $display("FAIL: see errors above");
    $fatal(1);
  end
end

endmodule

// File: ps_bus_bridge.sv
//////////////////////////////////////////////////////////////////////
// PS GP0 to system bus bridge
// AXI3 single beat slave, one write and one read in flight,
// sharing the system bus through the sequencer
//////////////////////////////////////////////////////////////////////

module ps_bus_bridge (
  input  logic                   axi_clk_i,
  input  logic                   rst_i,
  // AXI write address
  input  axi_pkg::axi_id_t       axi_awid_i,
  input  axi_pkg::axi_addr_t     axi_awaddr_i,
  input  axi_pkg::axi_len_t      axi_awlen_i,
  input  logic                   axi_awvalid_i,
  output logic                   axi_awready_o,
  // AXI write data
  input  axi_pkg::axi_data_t     axi_wdata_i,
  input  axi_pkg::axi_strb_t     axi_wstrb_i,
  input  logic                   axi_wlast_i,
  input  logic                   axi_wvalid_i,
  output logic                   axi_wready_o,
  // AXI write response
  output axi_pkg::axi_id_t       axi_bid_o,
  output axi_pkg::axi_resp_t     axi_bresp_o,
  output logic                   axi_bvalid_o,
  input  logic                   axi_bready_i,
  // AXI read address
  input  axi_pkg::axi_id_t       axi_arid_i,
  input  axi_pkg::axi_addr_t     axi_araddr_i,
  input  axi_pkg::axi_len_t      axi_arlen_i,
  input  logic                   axi_arvalid_i,
  output logic                   axi_arready_o,
  // AXI read data
  output axi_pkg::axi_id_t       axi_rid_o,
  output axi_pkg::axi_data_t     axi_rdata_o,
  output axi_pkg::axi_resp_t     axi_rresp_o,
  output logic                   axi_rlast_o,
  output logic                   axi_rvalid_o,
  input  logic                   axi_rready_i,
  // system bus
  output sys_bus_pkg::sys_addr_t sys_addr_o,
  output sys_bus_pkg::sys_data_t sys_wdata_o,
  output sys_bus_pkg::sys_sel_t  sys_sel_o,
  output logic                   sys_wen_o,
  output logic                   sys_ren_o,
  input  sys_bus_pkg::sys_data_t sys_rdata_i,
  input  logic                   sys_err_i,
  input  logic                   sys_ack_i
);

logic                   wr_req;     // write channel -> sequencer
sys_bus_pkg::sys_addr_t wr_addr;
sys_bus_pkg::sys_data_t wr_data;
sys_bus_pkg::sys_sel_t  wr_sel;
logic                   wr_done;
logic                   rd_req;     // read channel -> sequencer
sys_bus_pkg::sys_addr_t rd_addr;
logic                   rd_done;
logic                   xfer_err;   // shared result lines
sys_bus_pkg::sys_data_t xfer_rdata;

axi_wr_channel u_wr (
  .axi_clk_i (axi_clk_i), .rst_i (rst_i),
  .axi_awid_i (axi_awid_i), .axi_awaddr_i (axi_awaddr_i), .axi_awlen_i (axi_awlen_i),
  .axi_awvalid_i (axi_awvalid_i), .axi_awready_o (axi_awready_o),
  .axi_wdata_i (axi_wdata_i), .axi_wstrb_i (axi_wstrb_i), .axi_wlast_i (axi_wlast_i),
  .axi_wvalid_i (axi_wvalid_i), .axi_wready_o (axi_wready_o),
  .axi_bid_o (axi_bid_o), .axi_bresp_o (axi_bresp_o),
  .axi_bvalid_o (axi_bvalid_o), .axi_bready_i (axi_bready_i),
  .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_data_o (wr_data), .wr_sel_o (wr_sel),
  .wr_done_i (wr_done), .xfer_err_i (xfer_err)
);

axi_rd_channel u_rd (
  .axi_clk_i (axi_clk_i), .rst_i (rst_i),
  .axi_arid_i (axi_arid_i), .axi_araddr_i (axi_araddr_i), .axi_arlen_i (axi_arlen_i),
  .axi_arvalid_i (axi_arvalid_i), .axi_arready_o (axi_arready_o),
  .axi_rid_o (axi_rid_o), .axi_rdata_o (axi_rdata_o), .axi_rresp_o (axi_rresp_o),
  .axi_rlast_o (axi_rlast_o), .axi_rvalid_o (axi_rvalid_o), .axi_rready_i (axi_rready_i),
  .rd_req_o (rd_req), .rd_addr_o (rd_addr),
  .rd_done_i (rd_done), .xfer_err_i (xfer_err), .xfer_rdata_i (xfer_rdata)
);

sys_bus_sequencer u_seq (
  .axi_clk_i (axi_clk_i), .rst_i (rst_i),
  .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data), .wr_sel_i (wr_sel),
  .wr_done_o (wr_done),
  .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_done_o (rd_done),
  .xfer_err_o (xfer_err), .xfer_rdata_o (xfer_rdata),
  .sys_addr_o (sys_addr_o), .sys_wdata_o (sys_wdata_o), .sys_sel_o (sys_sel_o),
  .sys_wen_o (sys_wen_o), .sys_ren_o (sys_ren_o),
  .sys_rdata_i (sys_rdata_i), .sys_err_i (sys_err_i), .sys_ack_i (sys_ack_i)
);

endmodule

// File: sys_bus_sequencer.sv
//////////////////////////////////////////////////////////////////////
// System bus sequencer
// serves write and read requests one at a time with alternating
// priority, issues one strobe each and waits for ack or timeout
//////////////////////////////////////////////////////////////////////

module sys_bus_sequencer (
  input  logic                   axi_clk_i,
  input  logic                   rst_i,         // sync reset, active high
  // write channel
  input  logic                   wr_req_i,
  input  sys_bus_pkg::sys_addr_t wr_addr_i,
  input  sys_bus_pkg::sys_data_t wr_data_i,
  input  sys_bus_pkg::sys_sel_t  wr_sel_i,
  output logic                   wr_done_o,
  // read channel
  input  logic                   rd_req_i,
  input  sys_bus_pkg::sys_addr_t rd_addr_i,
  output logic                   rd_done_o,
  // result valid with either done pulse
  output logic                   xfer_err_o,
  output sys_bus_pkg::sys_data_t xfer_rdata_o,
  // system bus
  output sys_bus_pkg::sys_addr_t sys_addr_o,
  output sys_bus_pkg::sys_data_t sys_wdata_o,
  output sys_bus_pkg::sys_sel_t  sys_sel_o,
  output logic                   sys_wen_o,     // one cycle per access
  output logic                   sys_ren_o,
  input  sys_bus_pkg::sys_data_t sys_rdata_i,
  input  logic                   sys_err_i,
  input  logic                   sys_ack_i
);

sys_bus_pkg::seq_state_t   state_q;
sys_bus_pkg::sys_tmo_cnt_t tmo_cnt_q;   // cycles since strobe
logic                      cur_wr_q;    // access in flight is a write
logic                      last_wr_q;   // last served kind
logic                      wr_ok;
logic                      rd_ok;
logic                      pick_wr;
logic                      tmo;

// a channel finishing this cycle still shows its old request
assign wr_ok   = wr_req_i & ~wr_done_o;
assign rd_ok   = rd_req_i & ~rd_done_o;
assign pick_wr = wr_ok & (~rd_ok | ~last_wr_q);  // alternate on conflict
assign tmo     = (tmo_cnt_q == sys_bus_pkg::SYS_TMO_LAST);

//////////////////////////////////////////////////////////////////////
// FSM and strobes
//////////////////////////////////////////////////////////////////////

always_ff @(posedge axi_clk_i) begin
  if (rst_i) begin
    state_q   <= sys_bus_pkg::SEQ_IDLE;
    last_wr_q <= 1'b0;                          // first conflict goes to write
    sys_wen_o <= 1'b0;
    sys_ren_o <= 1'b0;
    wr_done_o <= 1'b0;
    rd_done_o <= 1'b0;
  end else begin
    sys_wen_o <= 1'b0;                          // pulses by default
    sys_ren_o <= 1'b0;
    wr_done_o <= 1'b0;
    rd_done_o <= 1'b0;
    case (state_q)
      sys_bus_pkg::SEQ_IDLE: begin
        if (wr_ok || rd_ok) begin
          state_q   <= sys_bus_pkg::SEQ_BUSY;
          last_wr_q <= pick_wr;
          sys_wen_o <= pick_wr;
          sys_ren_o <= ~pick_wr;
        end
      end
      sys_bus_pkg::SEQ_BUSY: begin
        if (sys_ack_i || tmo) begin             // ack wins over timeout
          state_q   <= sys_bus_pkg::SEQ_IDLE;
          wr_done_o <= cur_wr_q;
          rd_done_o <= ~cur_wr_q;
        end
      end
      default: state_q <= sys_bus_pkg::SEQ_IDLE;
    endcase
  end
end

// address, data and result payload
always_ff @(posedge axi_clk_i) begin
  if (state_q == sys_bus_pkg::SEQ_IDLE) begin
    tmo_cnt_q <= '0;
    cur_wr_q  <= pick_wr;
    if (pick_wr) begin
      sys_addr_o  <= wr_addr_i;
      sys_wdata_o <= wr_data_i;
      sys_sel_o   <= wr_sel_i;
    end else begin
      sys_addr_o  <= rd_addr_i;
      sys_sel_o   <= '1;                        // reads fetch the whole word
    end
  end else begin
    tmo_cnt_q    <= tmo_cnt_q + 1'b1;
    xfer_err_o   <= ~sys_ack_i | sys_err_i;     // timeout counts as error
    xfer_rdata_o <= sys_ack_i ? sys_rdata_i : '0;
  end
end

//////////////////////////////////////////////////////////////////////
// checks
//////////////////////////////////////////////////////////////////////

// each strobe serves a request that is still held
a_one_strobe : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  sys_wen_o |-> (!sys_ren_o && wr_req_i));

a_rd_strobe : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  sys_ren_o |-> (!sys_wen_o && rd_req_i));

// done pulse answers the request of its own kind
a_done_after_busy : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  wr_done_o |-> ($past(state_q == sys_bus_pkg::SEQ_BUSY) && wr_req_i));

a_rd_done_busy : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  rd_done_o |-> ($past(state_q == sys_bus_pkg::SEQ_BUSY) && rd_req_i));

endmodule

// File: axi_rd_channel.sv
//////////////////////////////////////////////////////////////////////
// AXI read channel
// takes one AR beat, asks the sequencer for a bus read and
// returns a single R beat with the AR ID
//////////////////////////////////////////////////////////////////////

module axi_rd_channel (
  input  logic                   axi_clk_i,     // GP0 clock
  input  logic                   rst_i,         // sync reset, active high
  // read address
  input  axi_pkg::axi_id_t       axi_arid_i,
  input  axi_pkg::axi_addr_t     axi_araddr_i,
  input  axi_pkg::axi_len_t      axi_arlen_i,   // single beat only
  input  logic                   axi_arvalid_i,
  output logic                   axi_arready_o,
  // read data
  output axi_pkg::axi_id_t       axi_rid_o,
  output axi_pkg::axi_data_t     axi_rdata_o,
  output axi_pkg::axi_resp_t     axi_rresp_o,
  output logic                   axi_rlast_o,
  output logic                   axi_rvalid_o,
  input  logic                   axi_rready_i,
  // sequencer side
  output logic                   rd_req_o,      // held until rd_done_i
  output sys_bus_pkg::sys_addr_t rd_addr_o,
  input  logic                   rd_done_i,     // one cycle pulse
  input  logic                   xfer_err_i,
  input  sys_bus_pkg::sys_data_t xfer_rdata_i   // zero after timeout
);

logic ar_hs;
logic r_hs;
logic ar_held_q;    // address captured, transaction open

assign ar_hs = axi_arvalid_i & axi_arready_o;
assign r_hs  = axi_rvalid_o  & axi_rready_i;

assign axi_arready_o = ~ar_held_q;
assign axi_rlast_o   = axi_rvalid_o;            // every beat is the last

always_ff @(posedge axi_clk_i) begin
  if (rst_i) begin
    ar_held_q    <= 1'b0;
    rd_req_o     <= 1'b0;
    axi_rvalid_o <= 1'b0;
  end else begin
    if (r_hs)
      ar_held_q <= 1'b0;
    else if (ar_hs)
      ar_held_q <= 1'b1;
    if (rd_done_i)
      rd_req_o <= 1'b0;
    else if (ar_held_q && !axi_rvalid_o)
      rd_req_o <= 1'b1;                         // one cycle after capture
    if (rd_done_i)
      axi_rvalid_o <= 1'b1;
    else if (r_hs)
      axi_rvalid_o <= 1'b0;
  end
end

// payload regs
always_ff @(posedge axi_clk_i) begin
  if (ar_hs) begin
    axi_rid_o <= axi_arid_i;
    rd_addr_o <= axi_araddr_i;
  end
  if (rd_done_i) begin
    axi_rdata_o <= xfer_rdata_i;
    axi_rresp_o <= xfer_err_i ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
  end
end

a_arlen_zero : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  ar_hs |-> (axi_arlen_i == '0));

endmodule

// File: axi_wr_channel.sv
//////////////////////////////////////////////////////////////////////
// AXI write channel
// takes one AW and one W beat in any order, asks the sequencer
// for a bus write and returns the B response with the AW ID
//////////////////////////////////////////////////////////////////////

module axi_wr_channel (
  input  logic                  axi_clk_i,      // GP0 clock
  input  logic                  rst_i,          // sync reset, active high
  // write address
  input  axi_pkg::axi_id_t      axi_awid_i,
  input  axi_pkg::axi_addr_t    axi_awaddr_i,
  input  axi_pkg::axi_len_t     axi_awlen_i,    // single beat only
  input  logic                  axi_awvalid_i,
  output logic                  axi_awready_o,
  // write data
  input  axi_pkg::axi_data_t    axi_wdata_i,
  input  axi_pkg::axi_strb_t    axi_wstrb_i,
  input  logic                  axi_wlast_i,
  input  logic                  axi_wvalid_i,
  output logic                  axi_wready_o,
  // write response
  output axi_pkg::axi_id_t      axi_bid_o,
  output axi_pkg::axi_resp_t    axi_bresp_o,
  output logic                  axi_bvalid_o,
  input  logic                  axi_bready_i,
  // sequencer side
  output logic                  wr_req_o,       // held until wr_done_i
  output sys_bus_pkg::sys_addr_t wr_addr_o,
  output sys_bus_pkg::sys_data_t wr_data_o,
  output sys_bus_pkg::sys_sel_t  wr_sel_o,
  input  logic                  wr_done_i,      // one cycle pulse
  input  logic                  xfer_err_i      // valid with wr_done_i
);

logic aw_hs;        // address accepted
logic w_hs;         // data accepted
logic b_hs;         // response taken
logic aw_held_q;
logic w_held_q;

assign aw_hs = axi_awvalid_i & axi_awready_o;
assign w_hs  = axi_wvalid_i  & axi_wready_o;
assign b_hs  = axi_bvalid_o  & axi_bready_i;

// each side stalls once it holds its beat
assign axi_awready_o = ~aw_held_q;
assign axi_wready_o  = ~w_held_q;

//////////////////////////////////////////////////////////////////////
// control
//////////////////////////////////////////////////////////////////////

always_ff @(posedge axi_clk_i) begin
  if (rst_i) begin
    aw_held_q    <= 1'b0;
    w_held_q     <= 1'b0;
    wr_req_o     <= 1'b0;
    axi_bvalid_o <= 1'b0;
  end else begin
    if (b_hs) begin                             // transaction closed
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else begin
      if (aw_hs) aw_held_q <= 1'b1;
      if (w_hs)  w_held_q  <= 1'b1;
    end
    if (wr_done_i)
      wr_req_o <= 1'b0;
    else if (aw_held_q && w_held_q && !axi_bvalid_o)
      wr_req_o <= 1'b1;                         // both halves present
    if (wr_done_i)
      axi_bvalid_o <= 1'b1;
    else if (b_hs)
      axi_bvalid_o <= 1'b0;
  end
end

// payload, loaded on handshake and held
always_ff @(posedge axi_clk_i) begin
  if (aw_hs) begin
    axi_bid_o <= axi_awid_i;                    // echoed in B
    wr_addr_o <= axi_awaddr_i;
  end
  if (w_hs) begin
    wr_data_o <= axi_wdata_i;
    wr_sel_o  <= axi_wstrb_i;                   // strobes map to byte select
  end
  if (wr_done_i)
    axi_bresp_o <= xfer_err_i ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
end

//////////////////////////////////////////////////////////////////////
// protocol checks
//////////////////////////////////////////////////////////////////////

a_awlen_zero : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  aw_hs |-> (axi_awlen_i == '0));

a_wlast_set : assert property (@(posedge axi_clk_i) disable iff (rst_i)
  w_hs |-> axi_wlast_i);

endmodule

// File: sys_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// System bus definitions
// widths, types and access timeout of the simple strobe/ack bus
//////////////////////////////////////////////////////////////////////

package sys_bus_pkg;

  localparam int unsigned SYS_ADDR_W = 32;
  localparam int unsigned SYS_DATA_W = 32;
  localparam int unsigned SYS_SEL_W  = SYS_DATA_W / 8;   // one bit per byte

  // cycles from strobe until an unanswered access is dropped
  localparam int unsigned SYS_TIMEOUT_CYCLES = 32;

  typedef logic [SYS_ADDR_W-1:0] sys_addr_t;    // bus address
  typedef logic [SYS_DATA_W-1:0] sys_data_t;    // bus data
  typedef logic [SYS_SEL_W-1:0]  sys_sel_t;     // byte select

  // timeout counter, counts busy cycles since the strobe
  typedef logic [$clog2(SYS_TIMEOUT_CYCLES)-1:0] sys_tmo_cnt_t;
  localparam sys_tmo_cnt_t SYS_TMO_LAST = sys_tmo_cnt_t'(SYS_TIMEOUT_CYCLES - 1);

  // sequencer FSM
  typedef enum logic {
    SEQ_IDLE = 1'b0,    // waiting for a request
    SEQ_BUSY = 1'b1     // strobe issued, waiting for ack
  } seq_state_t;

endpackage

// File: axi_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI slave port definitions
// widths, vector types and response codes of the PS GP0 AXI3 port
// as seen by the bus bridge (single beat only)
//////////////////////////////////////////////////////////////////////

package axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // field widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AXI_ID_W   = 12;         // GP0 master ID width
  localparam int unsigned AXI_ADDR_W = 32;         // byte address
  localparam int unsigned AXI_DATA_W = 32;         // one beat
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;
  localparam int unsigned AXI_LEN_W  = 4;          // AXI3 burst length
  localparam int unsigned AXI_RESP_W = 2;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef logic [AXI_ID_W-1:0]   axi_id_t;         // transaction ID
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;       // byte address
  typedef logic [AXI_DATA_W-1:0] axi_data_t;       // data beat
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;       // byte strobes
  typedef logic [AXI_LEN_W-1:0]  axi_len_t;        // must be zero here
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;       // B/R response

  // response codes, EXOKAY and DECERR never returned
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage
